//--- verilog/word_gen_consts.svh
`ifndef WG_CONSTS_SVH
`define WG_CONSTS_SVH

// word positions, position 0 steps fastest
`define WG_NUM_RANGES 3

// width of one character
`define WG_CHAR_BITS 8

// range RAM address width, up to 16 chars per range
`define WG_ADDR_BITS 4

`endif

//--- verilog/word_gen_pkg.sv
`default_nettype none

`include "word_gen_consts.svh"

package word_gen_pkg;

	// configuration record kinds
	typedef enum logic [1:0] {
		CONF_COUNT,	// value is the range's char count
		CONF_CHAR,	// value is the next char of the range
		CONF_START	// begin generation
	} conf_kind_t;

	typedef struct packed {
		conf_kind_t kind;
		logic [$clog2(`WG_NUM_RANGES)-1:0] range_idx;
		logic [`WG_CHAR_BITS-1:0] value;
	} conf_rec_t;

	// one range RAM word
	typedef struct packed {
		logic pre_end;	// char before the last one in the range
		logic [`WG_CHAR_BITS-1:0] ch;
	} range_entry_t;

	// generated word, position 0 in the low bits
	typedef struct packed {
		logic last;
		logic [`WG_NUM_RANGES-1:0][`WG_CHAR_BITS-1:0] chars;
	} word_t;

	// command broadcast from the emitter to every range
	typedef enum logic [1:0] {
		OP_IDLE,
		OP_START,	// load the first char of each range
		OP_NEXT		// step along the carry chain
	} op_cmd_t;

endpackage

`default_nettype wire

//--- verilog/range_ram.sv
`default_nettype none

`include "word_gen_consts.svh"

module range_ram (
	input wire OP_CLK,
	input wire rstb,

	input wire wr_en,
	input wire [`WG_ADDR_BITS-1:0] wr_addr,
	input wire word_gen_pkg::range_entry_t wr_data,

	input wire rd_en,
	input wire rd_clr,	// forces the read register to zero
	input wire [`WG_ADDR_BITS-1:0] rd_addr,
	output word_gen_pkg::range_entry_t rd_data
);
	import word_gen_pkg::*;

	range_entry_t mem [2**`WG_ADDR_BITS];

	// write port
	always_ff @(posedge OP_CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read port, clear wins over read
	always_ff @(posedge OP_CLK) begin
		if (rstb || rd_clr)
			rd_data <= '0;	// empty range reads as char 0
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- verilog/char_range.sv
`default_nettype none

`include "word_gen_consts.svh"

module char_range (
	input wire OP_CLK,
	input wire rstb,

	// configuration side, driven by the loader
	input wire count_wr,
	input wire count_eq0,
	input wire count_lt2,
	input wire char_wr,
	input wire [`WG_ADDR_BITS-1:0] char_addr,
	input wire word_gen_pkg::range_entry_t char_data,

	// generation side, driven by the emitter
	input wire op_done,
	input wire word_gen_pkg::op_cmd_t op_cmd,
	input wire step_in,
	output logic step_out,
	output logic [`WG_CHAR_BITS-1:0] char_out,
	output logic at_last
);
	import word_gen_pkg::*;

	logic eq0_q;	// no chars, output stays 0
	logic lt2_q;	// 0 or 1 chars, index never moves
	logic [`WG_ADDR_BITS-1:0] idx;	// address of the next read
	logic at_last_q;
	logic do_start;
	logic do_step;
	logic do_read;
	logic next_is_last;
	logic [`WG_ADDR_BITS-1:0] rd_addr;
	range_entry_t rd_data;

	assign do_start = (op_cmd == OP_START);
	assign do_step = (op_cmd == OP_NEXT) && step_in;
	assign do_read = do_start || do_step;

	// the char shown now is second to last, so the one read next is the last
	assign next_is_last = lt2_q || rd_data.pre_end;

	assign rd_addr = do_start ? '0 : idx;

	range_ram ram (
		.OP_CLK(OP_CLK),
		.rstb(rstb),
		.wr_en(char_wr),
		.wr_addr(char_addr),
		.wr_data(char_data),
		.rd_en(do_read),
		.rd_clr(eq0_q),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// range size flags, op_done empties the range again
	always_ff @(posedge OP_CLK) begin
		if (rstb || op_done) begin
			eq0_q <= 1'b1;
			lt2_q <= 1'b1;
		end else if (count_wr) begin
			eq0_q <= count_eq0;
			lt2_q <= count_lt2;
		end
	end

	// read index and last flag, updated together with the RAM read
	always_ff @(posedge OP_CLK) begin
		if (rstb) begin
			idx <= '0;
			at_last_q <= 1'b1;
		end else if (do_start) begin
			idx <= lt2_q ? '0 : `WG_ADDR_BITS'(1);
			at_last_q <= lt2_q;	// entry 0 is last only in a 1-char range
		end else if (do_step) begin
			idx <= next_is_last ? '0 : idx + 1'b1;
			at_last_q <= next_is_last;
		end
	end

	assign step_out = step_in && at_last_q;	// wrapping, carry to the next position
	assign char_out = rd_data.ch;
	assign at_last = at_last_q;

endmodule

`default_nettype wire

//--- verilog/word_gen_conf.sv
`default_nettype none

`include "word_gen_consts.svh"

module word_gen_conf (
	input wire OP_CLK,
	input wire rstb,

	// four-phase configuration port
	input wire conf_req,
	output logic conf_ack,
	input wire word_gen_pkg::conf_rec_t conf_data,

	input wire busy,	// emitter running, hold off records
	output logic start,

	// range write bus, strobes are one-hot per range
	output logic [`WG_NUM_RANGES-1:0] count_wr,
	output logic count_eq0,
	output logic count_lt2,
	output logic [`WG_NUM_RANGES-1:0] char_wr,
	output logic [`WG_ADDR_BITS-1:0] char_addr,
	output word_gen_pkg::range_entry_t char_data
);
	import word_gen_pkg::*;

	logic [`WG_ADDR_BITS:0] count_q [`WG_NUM_RANGES];
	logic [`WG_ADDR_BITS-1:0] wr_ptr [`WG_NUM_RANGES];
	logic take;
	logic idx_ok;

	// accept a new record once, and only when idle
	assign take = conf_req && !conf_ack && !busy;
	assign idx_ok = (conf_data.range_idx < `WG_NUM_RANGES);

	// handshake, strobes and per-range bookkeeping
	always_ff @(posedge OP_CLK) begin
		if (rstb) begin
			conf_ack <= 1'b0;
			start <= 1'b0;
			count_wr <= '0;
			char_wr <= '0;
			for (int r = 0; r < `WG_NUM_RANGES; r++) begin
				count_q[r] <= '0;
				wr_ptr[r] <= '0;
			end
		end else begin
			start <= 1'b0;	// strobes last one cycle
			count_wr <= '0;
			char_wr <= '0;
			if (take) begin
				conf_ack <= 1'b1;
				case (conf_data.kind)
					CONF_COUNT: begin
						if (idx_ok) begin
							count_q[conf_data.range_idx] <= conf_data.value[`WG_ADDR_BITS:0];
							wr_ptr[conf_data.range_idx] <= '0;
							count_wr[conf_data.range_idx] <= 1'b1;
						end
					end
					CONF_CHAR: begin
						if (idx_ok) begin
							char_wr[conf_data.range_idx] <= 1'b1;
							wr_ptr[conf_data.range_idx] <= wr_ptr[conf_data.range_idx] + 1'b1;
						end
					end
					CONF_START: start <= 1'b1;
					default: ;
				endcase
			end else if (!conf_req) begin
				conf_ack <= 1'b0;	// source released req
			end
		end
	end

	// shared data for whichever range is strobed
	always_ff @(posedge OP_CLK) begin
		if (take) begin
			count_eq0 <= (conf_data.value == '0);
			count_lt2 <= (conf_data.value < `WG_CHAR_BITS'(2));
			char_addr <= wr_ptr[conf_data.range_idx];
			char_data.ch <= conf_data.value;
			// mark the second to last char, never matches for counts below 2
			char_data.pre_end <= ({1'b0, wr_ptr[conf_data.range_idx]} ==
				count_q[conf_data.range_idx] - (`WG_ADDR_BITS+1)'(2));
		end
	end

endmodule

`default_nettype wire

//--- verilog/word_emitter.sv
`default_nettype none

`include "word_gen_consts.svh"

module word_emitter (
	input wire OP_CLK,
	input wire rstb,

	input wire start,
	output logic busy,

	// range bus
	output word_gen_pkg::op_cmd_t op_cmd,
	output logic step,	// into the carry chain at range 0
	input wire [`WG_NUM_RANGES-1:0][`WG_CHAR_BITS-1:0] chars,
	input wire [`WG_NUM_RANGES-1:0] at_last,
	output logic op_done,

	// four-phase word port
	output logic word_req,
	input wire word_ack,
	output word_gen_pkg::word_t word_data
);
	import word_gen_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,	// ranges read entry 0
		S_WAIT,		// RAM outputs settle, word gets latched
		S_OFFER,	// req high, waiting for ack
		S_RELEASE,	// req low, waiting for ack to drop
		S_NEXT		// ranges step
	} state_t;

	state_t state;

	always_ff @(posedge OP_CLK) begin
		if (rstb) begin
			state <= S_IDLE;
			word_req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start)
						state <= S_START;
				end
				S_START: state <= S_WAIT;
				S_WAIT: begin
					word_req <= 1'b1;
					state <= S_OFFER;
				end
				S_OFFER: begin
					if (word_ack) begin
						word_req <= 1'b0;
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					// word done when ack falls
					if (!word_ack)
						state <= word_data.last ? S_IDLE : S_NEXT;
				end
				S_NEXT: state <= S_WAIT;
				default: state <= S_IDLE;
			endcase
		end
	end

	// word is captured as req goes up and held until the next one
	always_ff @(posedge OP_CLK) begin
		if (state == S_WAIT) begin
			word_data.chars <= chars;
			word_data.last <= &at_last;	// every position on its last char
		end
	end

	always_comb begin
		case (state)
			S_START: op_cmd = OP_START;
			S_NEXT: op_cmd = OP_NEXT;
			default: op_cmd = OP_IDLE;
		endcase
	end

	assign step = (state == S_NEXT);

	// last word fully handed over, ranges go back to empty
	assign op_done = (state == S_RELEASE) && !word_ack && word_data.last;

	// op_done cycle counts as busy so no count write races the clear
	assign busy = (state != S_IDLE);

endmodule

`default_nettype wire

//--- verilog/word_gen_top.sv
`default_nettype none

`include "word_gen_consts.svh"

module word_gen_top (
	input wire OP_CLK,
	input wire rstb,

	input wire conf_req,
	output logic conf_ack,
	input wire word_gen_pkg::conf_rec_t conf_data,

	output logic word_req,
	input wire word_ack,
	output word_gen_pkg::word_t word_data
);
	import word_gen_pkg::*;

	logic busy;
	logic start;
	logic op_done;
	op_cmd_t op_cmd;

	logic [`WG_NUM_RANGES-1:0] count_wr;
	logic count_eq0;
	logic count_lt2;
	logic [`WG_NUM_RANGES-1:0] char_wr;
	logic [`WG_ADDR_BITS-1:0] char_addr;
	range_entry_t char_data;

	// carry chain, the top bit falls off since the run ends on the last word
	logic [`WG_NUM_RANGES:0] step_chain;
	logic [`WG_NUM_RANGES-1:0][`WG_CHAR_BITS-1:0] chars;
	logic [`WG_NUM_RANGES-1:0] at_last;

	word_gen_conf conf (
		.OP_CLK(OP_CLK),
		.rstb(rstb),
		.conf_req(conf_req),
		.conf_ack(conf_ack),
		.conf_data(conf_data),
		.busy(busy),
		.start(start),
		.count_wr(count_wr),
		.count_eq0(count_eq0),
		.count_lt2(count_lt2),
		.char_wr(char_wr),
		.char_addr(char_addr),
		.char_data(char_data)
	);

	for (genvar r = 0; r < `WG_NUM_RANGES; r++) begin : g_range
		char_range range (
			.OP_CLK(OP_CLK),
			.rstb(rstb),
			.count_wr(count_wr[r]),
			.count_eq0(count_eq0),
			.count_lt2(count_lt2),
			.char_wr(char_wr[r]),
			.char_addr(char_addr),
			.char_data(char_data),
			.op_done(op_done),
			.op_cmd(op_cmd),
			.step_in(step_chain[r]),
			.step_out(step_chain[r+1]),
			.char_out(chars[r]),
			.at_last(at_last[r])
		);
	end

	word_emitter emitter (
		.OP_CLK(OP_CLK),
		.rstb(rstb),
		.start(start),
		.busy(busy),
		.op_cmd(op_cmd),
		.step(step_chain[0]),
		.chars(chars),
		.at_last(at_last),
		.op_done(op_done),
		.word_req(word_req),
		.word_ack(word_ack),
		.word_data(word_data)
	);

endmodule

`default_nettype wire

//--- dv/word_gen_assert.sv
`default_nettype none

module word_gen_assert (
	input wire OP_CLK,
	input wire rstb,
	input wire conf_req,
	input wire conf_ack,
	input wire word_req,
	input wire word_ack,
	input wire word_gen_pkg::word_t word_data,
	input wire step
);

	// word held from req rising until ack falls
	word_stable: assert property (@(posedge OP_CLK) disable iff (rstb)
		(word_req || word_ack) && $past(word_req || word_ack) |-> $stable(word_data))
		else $error("word_data changed during a word handshake");

	req_waits_ack: assert property (@(posedge OP_CLK) disable iff (rstb)
		$fell(word_req) |-> $past(word_ack))
		else $error("word_req dropped before word_ack rose");

	ack_needs_req: assert property (@(posedge OP_CLK) disable iff (rstb)
		$rose(conf_ack) |-> $past(conf_req))
		else $error("conf_ack rose without conf_req");

	// ranges never move while a word is on offer
	no_step_in_offer: assert property (@(posedge OP_CLK) disable iff (rstb)
		step |-> !word_req)
		else $error("step asserted while word_req high");

endmodule

bind word_gen_top word_gen_assert handshake_checks (
	.OP_CLK(OP_CLK),
	.rstb(rstb),
	.conf_req(conf_req),
	.conf_ack(conf_ack),
	.word_req(word_req),
	.word_ack(word_ack),
	.word_data(word_data),
	.step(step_chain[0])
);

`default_nettype wire

//--- dv/word_gen_tb.sv
`default_nettype none

`include "word_gen_consts.svh"

module word_gen_tb;
	import word_gen_pkg::*;

	localparam int NR = `WG_NUM_RANGES;
	localparam int MAX_CHARS = 1 << `WG_ADDR_BITS;
	localparam int IDX_BITS = $clog2(`WG_NUM_RANGES);
	localparam int N_CASES = 5;

	logic OP_CLK;
	logic rstb;
	logic conf_req;
	logic conf_ack;
	conf_rec_t conf_data;
	logic word_req;
	logic word_ack;
	word_t word_data;

	// stimulus table with chars per range, word count, ack mode and count-0 records
	int cnt_tab [N_CASES][NR];
	logic [`WG_CHAR_BITS-1:0] chr_tab [N_CASES][NR][MAX_CHARS];
	int words_tab [N_CASES];
	bit rand_tab [N_CASES];
	bit send_empty_tab [N_CASES];

	int mismatches = 0;
	int other_errors = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	logic [31:0] lcg_state = 32'h15bd;

	word_gen_top DUT (
		.OP_CLK(OP_CLK),
		.rstb(rstb),
		.conf_req(conf_req),
		.conf_ack(conf_ack),
		.conf_data(conf_data),
		.word_req(word_req),
		.word_ack(word_ack),
		.word_data(word_data)
	);

	initial begin
		OP_CLK = 1'b0;
		forever #5 OP_CLK = ~OP_CLK;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic set_case(input int c, input string s0, input string s1, input string s2,
			input int words, input bit rnd, input bit send_empty);
		string s [NR];
		s[0] = s0;
		s[1] = s1;
		s[2] = s2;
		for (int r = 0; r < NR; r++) begin
			cnt_tab[c][r] = s[r].len();
			for (int i = 0; i < s[r].len(); i++)
				chr_tab[c][r][i] = s[r][i];
		end
		words_tab[c] = words;
		rand_tab[c] = rnd;
		send_empty_tab[c] = send_empty;
	endtask

	task end_run();
		$display("mismatches %0d, other errors %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	// one four-phase record entered and left just after a falling edge
	task automatic send_conf(input conf_kind_t kind, input int r, input int value);
		conf_data.kind = kind;
		conf_data.range_idx = IDX_BITS'(r);
		conf_data.value = `WG_CHAR_BITS'(value);
		conf_req = 1'b1;
		@(negedge OP_CLK);
		while (!conf_ack)
			@(negedge OP_CLK);	// held off while busy
		conf_req = 1'b0;
		@(negedge OP_CLK);
		while (conf_ack)
			@(negedge OP_CLK);
	endtask

	task automatic expect_quiet(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge OP_CLK);
			if (word_req !== 1'b0) begin
				other_errors++;
				$display("word offered without a configured run");
			end
		end
	endtask

	task automatic run_case(input int c);
		int idx [NR];
		int w;
		int delay;
		bit exp_last;
		bit got_last;
		bit carry;
		logic [`WG_CHAR_BITS-1:0] exp_ch;
		for (int r = 0; r < NR; r++) begin
			// without a count record an empty range relies on op_done clearing it
			if (cnt_tab[c][r] > 0 || send_empty_tab[c])
				send_conf(CONF_COUNT, r, cnt_tab[c][r]);
			for (int i = 0; i < cnt_tab[c][r]; i++)
				send_conf(CONF_CHAR, r, chr_tab[c][r][i]);
			idx[r] = 0;
		end
		send_conf(CONF_START, 0, 0);
		w = 0;
		got_last = 1'b0;
		while (!got_last) begin
			while (!word_req)
				@(negedge OP_CLK);
			// odometer model where a range below two chars always counts as on its last
			exp_last = 1'b1;
			for (int r = 0; r < NR; r++) begin
				exp_ch = (cnt_tab[c][r] == 0) ? '0 : chr_tab[c][r][idx[r]];
				if (word_data.chars[r] !== exp_ch) begin
					mismatches++;
					$display("mismatch case %0d word %0d word_data.chars[%0d]: got %h expected %h",
						c, w, r, word_data.chars[r], exp_ch);
				end
				if (cnt_tab[c][r] > 1 && idx[r] != cnt_tab[c][r] - 1)
					exp_last = 1'b0;
			end
			if (word_data.last !== exp_last) begin
				mismatches++;
				$display("mismatch case %0d word %0d word_data.last: got %h expected %h",
					c, w, word_data.last, exp_last);
			end
			got_last = (word_data.last === 1'b1) || exp_last;
			delay = 0;
			if (rand_tab[c]) begin
				lcg_state = lcg_next(lcg_state);
				delay = int'(lcg_state[20:16]) % 6;
			end
			repeat (delay) @(negedge OP_CLK);
			word_ack = 1'b1;
			@(negedge OP_CLK);
			while (word_req)
				@(negedge OP_CLK);
			word_ack = 1'b0;
			w++;
			carry = 1'b1;	// position 0 always steps
			for (int r = 0; r < NR; r++) begin
				if (carry && cnt_tab[c][r] > 1) begin
					idx[r]++;
					if (idx[r] == cnt_tab[c][r])
						idx[r] = 0;
					else
						carry = 1'b0;
				end
			end
		end
		if (w != words_tab[c]) begin
			other_errors++;
			$display("case %0d delivered %0d words where %0d were expected", c, w, words_tab[c]);
		end
		expect_quiet(8);	// nothing past the last word
	endtask

	always @(posedge OP_CLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			other_errors++;
			$display("timeout, run still going after %0d cycles", cycle_limit);
			end_run();
		end
	end

	initial begin
		int total_words;
		int total_records;
		rstb = 1'b1;
		conf_req = 1'b0;
		conf_data = '0;
		word_ack = 1'b0;
		set_case(0, "abc", "xy", "0123", 24, 1'b0, 1'b1);
		set_case(1, "abc", "xy", "0123", 24, 1'b1, 1'b1);	// same run with random ack
		set_case(2, "k", "", "pqr", 3, 1'b1, 1'b1);
		set_case(3, "MN", "vwxyz", "", 10, 1'b1, 1'b0);	// old chars must not show up
		set_case(4, "", "", "", 1, 1'b0, 1'b1);
		total_words = 0;
		total_records = 0;
		for (int c = 0; c < N_CASES; c++) begin
			total_words += words_tab[c];
			total_records += NR + 1;
			for (int r = 0; r < NR; r++)
				total_records += cnt_tab[c][r];
		end
		// up to 16 cycles per word, 8 per record, plus reset and idle checks
		cycle_limit = total_words * 16 + total_records * 8 + 20 * (N_CASES + 1);
		repeat (3) @(negedge OP_CLK);
		rstb = 1'b0;
		if (word_req !== 1'b0) begin
			mismatches++;
			$display("mismatch word_req after reset: got %h expected 0", word_req);
		end
		if (conf_ack !== 1'b0) begin
			mismatches++;
			$display("mismatch conf_ack after reset: got %h expected 0", conf_ack);
		end
		expect_quiet(8);
		for (int c = 0; c < N_CASES; c++)
			run_case(c);
		end_run();
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/word_gen_pkg.sv
verilog/range_ram.sv
verilog/char_range.sv
verilog/word_gen_conf.sv
verilog/word_emitter.sv
verilog/word_gen_top.sv
dv/word_gen_assert.sv
dv/word_gen_tb.sv
